// File: hw/rob_pkg.sv
package rob_pkg;

    localparam int ROB_SIZE  = 16;
    localparam int ROB_IDX_W = 4;
    // holds 0 up to ROB_SIZE
    localparam int ROB_CNT_W = 5;
    localparam int ROB_WIDTH = 2;
    localparam int WB_PORTS  = 2;
    localparam int EXC_W     = 4;

    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // wrap bit on top so a plain add carries into it
    typedef struct packed {
        logic     wrap;
        rob_idx_t idx;
    } rob_ptr_t;

    typedef logic [EXC_W-1:0] exc_code_t;

    localparam exc_code_t EXC_NONE = '1;

    typedef struct packed {
        logic       we;
        logic [4:0] rd;
        logic [5:0] prd;
    } rob_entry_t;

endpackage

// File: hw/rob_head_if.sv
`timescale 1ns/1ps

interface rob_head_if import rob_pkg::*; ();

    rob_idx_t                      head;
    logic [ROB_CNT_W-1:0]          count;
    rob_entry_t [ROB_WIDTH-1:0]    entry;
    logic [ROB_WIDTH-1:0]          done;
    exc_code_t [ROB_WIDTH-1:0]     exc;

    // payload storage reads at head, head+1
    modport ram (
        input  head,
        output entry
    );

    modport status (
        input  head,
        output done,
        output exc
    );

    modport commit (
        input head,
        input count,
        input entry,
        input done,
        input exc
    );

endinterface

// File: hw/rob_ptrs.sv
`timescale 1ns/1ps

module rob_ptrs import rob_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [1:0]           alloc_num,
    input  logic [1:0]           commit_num,
    input  logic                 flush,
    output logic                 full,
    output logic                 alloc_ok,
    output rob_ptr_t             tail_ptr,
    output rob_ptr_t             head_ptr,
    output rob_idx_t             head,
    output logic [ROB_CNT_W-1:0] count
);

    logic [ROB_CNT_W-1:0] free_cnt;
    logic [ROB_CNT_W-1:0] add_num;
    logic [ROB_CNT_W-1:0] sub_num;

    assign free_cnt = ROB_CNT_W'(ROB_SIZE) - count;
    assign full     = ROB_CNT_W'(alloc_num) > free_cnt;

    // nothing enters while the buffer is being flushed
    assign alloc_ok = ~full & ~flush;

    assign add_num = alloc_ok ? ROB_CNT_W'(alloc_num) : '0;
    assign sub_num = ROB_CNT_W'(commit_num);

    assign head = head_ptr.idx;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            count    <= '0;
        end else if (flush) begin
            // drop everything still in flight
            head_ptr <= tail_ptr;
            count    <= '0;
        end else begin
            // carry out of the index flips the wrap bit
            head_ptr <= head_ptr + sub_num;
            tail_ptr <= tail_ptr + add_num;
            count    <= count + add_num - sub_num;
        end
    end

    // commit and allocation amounts come from different blocks
    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst)
        count <= ROB_CNT_W'(ROB_SIZE)
    ) else $error("rob occupancy above ROB_SIZE");

endmodule

// File: hw/rob_status.sv
`timescale 1ns/1ps

module rob_status import rob_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      alloc_ok,
    input  logic [1:0]                alloc_num,
    input  rob_idx_t                  tail,
    input  logic [WB_PORTS-1:0]       wb_en,
    input  rob_idx_t [WB_PORTS-1:0]   wb_idx,
    input  exc_code_t [WB_PORTS-1:0]  wb_exc,
    rob_head_if.status                hif
);

    logic [ROB_SIZE-1:0] done_q;
    exc_code_t           exc_q [ROB_SIZE];
    rob_idx_t            alloc_idx [ROB_WIDTH];
    rob_idx_t            rd_idx [ROB_WIDTH];

    for (genvar i = 0; i < ROB_WIDTH; i++) begin : g_lane
        assign alloc_idx[i] = tail + rob_idx_t'(i);
        assign rd_idx[i]    = hif.head + rob_idx_t'(i);
        assign hif.done[i]  = done_q[rd_idx[i]];
        assign hif.exc[i]   = exc_q[rd_idx[i]];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            done_q <= '0;
        end else begin
            for (int i = 0; i < ROB_WIDTH; i++) begin
                if (alloc_ok && (int'(alloc_num) > i)) begin
                    done_q[alloc_idx[i]] <= 1'b0;
                end
            end
            // later writes win, so writeback beats a clear on the same slot
            for (int p = 0; p < WB_PORTS; p++) begin
                if (wb_en[p]) begin
                    done_q[wb_idx[p]] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < WB_PORTS; p++) begin
            if (wb_en[p]) begin
                exc_q[wb_idx[p]] <= wb_exc[p];
            end
        end
    end

    a_wb_distinct: assert property (
        @(posedge clk) disable iff (!rst)
        !(wb_en[0] && wb_en[1] && (wb_idx[0] == wb_idx[1]))
    ) else $error("both writeback ports hit the same rob index");

endmodule

// File: hw/rob_entry_ram.sv
`timescale 1ns/1ps

module rob_entry_ram import rob_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        alloc_ok,
    input  logic [1:0]                  alloc_num,
    input  rob_idx_t                    tail,
    input  rob_entry_t [ROB_WIDTH-1:0]  alloc_entry,
    rob_head_if.ram                     hif
);

    rob_entry_t mem [ROB_SIZE];
    rob_idx_t   wr_idx [ROB_WIDTH];

    for (genvar i = 0; i < ROB_WIDTH; i++) begin : g_port
        assign wr_idx[i]    = tail + rob_idx_t'(i);
        // async read of the two oldest slots
        assign hif.entry[i] = mem[hif.head + rob_idx_t'(i)];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            mem <= '{default: '0};
        end else if (alloc_ok) begin
            for (int i = 0; i < ROB_WIDTH; i++) begin
                if (int'(alloc_num) > i) begin
                    mem[wr_idx[i]] <= alloc_entry[i];
                end
            end
        end
    end

endmodule

// File: hw/rob_commit.sv
`timescale 1ns/1ps

module rob_commit import rob_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  rob_ptr_t                          head_ptr,
    rob_head_if.commit                        hif,
    output logic [$clog2(ROB_WIDTH+1)-1:0]    commit_num,
    output logic                              flush,
    output logic [ROB_WIDTH-1:0]              commit_en,
    output rob_entry_t [ROB_WIDTH-1:0]        commit_entry,
    output logic                              exc_valid,
    output rob_ptr_t                          exc_ptr,
    output exc_code_t                         exc_code
);

    logic [ROB_CNT_W-1:0] avail;
    logic [ROB_WIDTH-1:0] retire;
    logic                 fault;
    logic [ROB_IDX_W:0]   fault_ptr;
    exc_code_t            fault_code;

    assign flush = exc_valid;

    // during the flush cycle the head is treated as empty
    assign avail = flush ? '0 : hif.count;

    always_comb begin
        logic run;
        run        = 1'b1;
        retire     = '0;
        fault      = 1'b0;
        fault_ptr  = head_ptr;
        fault_code = EXC_NONE;
        commit_num = '0;
        for (int i = 0; i < ROB_WIDTH; i++) begin
            // ready prefix from lane 0, cut at the first fault
            run = run & (ROB_CNT_W'(i) < avail) & hif.done[i] & ~fault;
            if (run) begin
                if (hif.exc[i] != EXC_NONE) begin
                    fault      = 1'b1;
                    fault_ptr  = head_ptr + (ROB_IDX_W+1)'(i);
                    fault_code = hif.exc[i];
                end else begin
                    retire[i]  = 1'b1;
                    commit_num = commit_num + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            commit_en <= '0;
            exc_valid <= 1'b0;
        end else begin
            commit_en <= retire;
            exc_valid <= fault;
        end
    end

    always_ff @(posedge clk) begin
        commit_entry <= hif.entry;
        if (fault) begin
            exc_ptr  <= fault_ptr;
            exc_code <= fault_code;
        end
    end

    // lanes retire strictly in order
    a_commit_contig: assert property (
        @(posedge clk) disable iff (!rst)
        (commit_en & (commit_en + 1'b1)) == '0
    ) else $error("commit_en has a gap");

endmodule

// File: hw/rob.sv
`timescale 1ns/1ps

module rob import rob_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [1:0]                  alloc_num,
    input  rob_entry_t [ROB_WIDTH-1:0]  alloc_entry,
    input  logic [WB_PORTS-1:0]         wb_en,
    input  rob_idx_t [WB_PORTS-1:0]     wb_idx,
    input  exc_code_t [WB_PORTS-1:0]    wb_exc,
    output logic                        full,
    output rob_ptr_t                    alloc_ptr,
    output logic [ROB_WIDTH-1:0]        commit_en,
    output rob_entry_t [ROB_WIDTH-1:0]  commit_entry,
    output logic                        exc_valid,
    output rob_ptr_t                    exc_ptr,
    output exc_code_t                   exc_code
);

    logic     alloc_ok;
    logic     flush;
    rob_ptr_t head_ptr;
    logic [$clog2(ROB_WIDTH+1)-1:0] commit_num;

    rob_head_if head_bus ();

    rob_ptrs ptrs_inst (
        .clk        (clk),
        .rst        (rst),
        .alloc_num  (alloc_num),
        .commit_num (commit_num),
        .flush      (flush),
        .full       (full),
        .alloc_ok   (alloc_ok),
        .tail_ptr   (alloc_ptr),
        .head_ptr   (head_ptr),
        .head       (head_bus.head),
        .count      (head_bus.count)
    );

    rob_status status_inst (
        .clk       (clk),
        .rst       (rst),
        .alloc_ok  (alloc_ok),
        .alloc_num (alloc_num),
        .tail      (alloc_ptr.idx),
        .wb_en     (wb_en),
        .wb_idx    (wb_idx),
        .wb_exc    (wb_exc),
        .hif       (head_bus.status)
    );

    rob_entry_ram ram_inst (
        .clk         (clk),
        .rst         (rst),
        .alloc_ok    (alloc_ok),
        .alloc_num   (alloc_num),
        .tail        (alloc_ptr.idx),
        .alloc_entry (alloc_entry),
        .hif         (head_bus.ram)
    );

    rob_commit commit_inst (
        .clk          (clk),
        .rst          (rst),
        .head_ptr     (head_ptr),
        .hif          (head_bus.commit),
        .commit_num   (commit_num),
        .flush        (flush),
        .commit_en    (commit_en),
        .commit_entry (commit_entry),
        .exc_valid    (exc_valid),
        .exc_ptr      (exc_ptr),
        .exc_code     (exc_code)
    );

endmodule

// File: tests/rob_tb.sv
`timescale 1ns/1ps

module rob_tb import rob_pkg::*; ();

    localparam int CLK_PERIOD = 4;
    localparam int NUM_OPS    = 80;
    localparam int TIMEOUT_NS = NUM_OPS * 20 * CLK_PERIOD;

    typedef struct {
        rob_entry_t entry;
        rob_ptr_t   ptr;
    } model_item_t;

    logic                       clk = 1'b0;
    logic                       rst;
    logic [1:0]                 alloc_num;
    rob_entry_t [ROB_WIDTH-1:0] alloc_entry;
    logic [WB_PORTS-1:0]        wb_en;
    rob_idx_t [WB_PORTS-1:0]    wb_idx;
    exc_code_t [WB_PORTS-1:0]   wb_exc;
    logic                       full;
    rob_ptr_t                   alloc_ptr;
    logic [ROB_WIDTH-1:0]       commit_en;
    rob_entry_t [ROB_WIDTH-1:0] commit_entry;
    logic                       exc_valid;
    rob_ptr_t                   exc_ptr;
    exc_code_t                  exc_code;

    // model of the entries in flight, oldest first
    model_item_t          model_q [$];
    logic                 wb_done [ROB_SIZE];
    exc_code_t            exp_exc [ROB_SIZE];
    rob_ptr_t             exp_tail;
    int                   commit_total;
    int                   exc_seen;
    rob_ptr_t             exc_ptr_seen;
    exc_code_t            exc_code_seen;
    logic [ROB_WIDTH-1:0] exc_lanes_seen;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rob rob_inst (.*);

    task automatic stop_with(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
        if (actual !== expected) begin
            $display("[ERROR] %0t: %s (got %0h, expected %0h)", $time, msg, actual, expected);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin : commit_monitor
        model_item_t oldest;
        if (rst) begin
            for (int i = 0; i < ROB_WIDTH; i++) begin
                if (commit_en[i]) begin
                    if (model_q.size() == 0) begin
                        stop_with("a commit came out while no allocated entry was outstanding");
                    end else begin
                        oldest = model_q.pop_front();
                        check_eq(32'(commit_entry[i]), 32'(oldest.entry), "commit_entry");
                        check_eq(32'(wb_done[oldest.ptr.idx]), 1, "commit before writeback");
                        check_eq(32'(exp_exc[oldest.ptr.idx]), 32'(EXC_NONE),
                                 "faulting entry committed");
                        commit_total++;
                    end
                end
            end
            // lanes that retire alongside an exception are older than it
            if (exc_valid) begin
                exc_seen++;
                exc_ptr_seen   = exc_ptr;
                exc_code_seen  = exc_code;
                exc_lanes_seen = commit_en;
                if (model_q.size() == 0) begin
                    stop_with("an exception was reported while no entry was outstanding");
                end else begin
                    check_eq(32'(exc_ptr), 32'(model_q[0].ptr), "exc_ptr");
                    check_eq(32'(exc_code), 32'(exp_exc[model_q[0].ptr.idx]), "exc_code");
                    check_eq(32'(exc_code != EXC_NONE), 1, "exception without fault code");
                    model_q.delete();
                end
            end
        end
    end

    task automatic alloc_burst(input int total);
        rob_entry_t [ROB_WIDTH-1:0] bus;
        model_item_t                item;
        int                         n;
        int                         left;
        left = total;
        @(posedge clk);
        while (left > 0) begin
            n = (left > ROB_WIDTH) ? ROB_WIDTH : left;
            for (int i = 0; i < ROB_WIDTH; i++) begin
                bus[i] = 12'($urandom);
            end
            alloc_num   <= 2'(n);
            alloc_entry <= bus;
            @(posedge clk);
            check_eq(32'(full), 0, "full while space was left");
            check_eq(32'(alloc_ptr), 32'(exp_tail), "alloc_ptr");
            for (int i = 0; i < n; i++) begin
                item.entry = bus[i];
                item.ptr   = exp_tail + 5'(i);
                model_q.push_back(item);
                wb_done[item.ptr.idx] = 1'b0;
                exp_exc[item.ptr.idx] = EXC_NONE;
            end
            exp_tail = exp_tail + 5'(n);
            left     = left - n;
        end
        alloc_num <= '0;
    endtask

    // writes back n entries from base in a shuffled order, two ports per cycle
    task automatic complete_range(input rob_idx_t base, input int n, input int fault_off,
                                  input exc_code_t code);
        int                       order [$];
        int                       pick;
        int                       tmp;
        int                       k;
        logic [WB_PORTS-1:0]      en;
        rob_idx_t [WB_PORTS-1:0]  ix;
        exc_code_t [WB_PORTS-1:0] ex;
        for (int i = 0; i < n; i++) begin
            order.push_back(i);
        end
        for (int i = n - 1; i > 0; i--) begin
            pick        = int'($urandom_range(i, 0));
            tmp         = order[i];
            order[i]    = order[pick];
            order[pick] = tmp;
        end
        k = 0;
        while (k < n) begin
            @(posedge clk);
            en = '0;
            ix = '0;
            ex = {WB_PORTS{EXC_NONE}};
            for (int p = 0; p < WB_PORTS; p++) begin
                if (k < n) begin
                    ix[p] = base + rob_idx_t'(order[k]);
                    ex[p] = (order[k] == fault_off) ? code : EXC_NONE;
                    en[p] = 1'b1;
                    wb_done[ix[p]] = 1'b1;
                    exp_exc[ix[p]] = ex[p];
                    k++;
                end
            end
            wb_en  <= en;
            wb_idx <= ix;
            wb_exc <= ex;
        end
        @(posedge clk);
        wb_en <= '0;
    endtask

    task automatic wait_drain();
        while (model_q.size() != 0) begin
            @(posedge clk);
        end
    endtask

    task automatic reset_and_alloc_ptrs();
        rob_ptr_t start;
        @(posedge clk);
        check_eq(32'(full), 0, "full after reset");
        check_eq(32'(commit_en), 0, "commit_en after reset");
        check_eq(32'(exc_valid), 0, "exc_valid after reset");
        check_eq(32'(alloc_ptr), 0, "alloc_ptr after reset");
        start = exp_tail;
        alloc_burst(ROB_SIZE);
        complete_range(start.idx, ROB_SIZE, -1, EXC_NONE);
        wait_drain();
        check_eq(32'(alloc_ptr), 32'(5'b1_0000), "alloc_ptr after one lap");
    endtask

    task automatic inorder_commit();
        rob_ptr_t start;
        int       c0;
        start = exp_tail;
        c0    = commit_total;
        alloc_burst(8);
        complete_range(start.idx, 8, -1, EXC_NONE);
        wait_drain();
        check_eq(32'(commit_total), 32'(c0 + 8), "commits after shuffled writeback");
    endtask

    task automatic full_backpressure();
        rob_ptr_t start;
        int       c0;
        start = exp_tail;
        alloc_burst(ROB_SIZE);
        @(posedge clk);
        alloc_num <= 2'd1;
        @(posedge clk);
        check_eq(32'(full), 1, "full with 16 entries held");
        alloc_num <= 2'd2;
        @(posedge clk);
        check_eq(32'(full), 1, "full for alloc_num 2");
        check_eq(32'(alloc_ptr), 32'(exp_tail), "alloc_ptr after rejected allocation");
        alloc_num <= '0;
        c0 = commit_total;
        complete_range(start.idx, 2, -1, EXC_NONE);
        while (commit_total < c0 + 2) begin
            @(posedge clk);
        end
        alloc_burst(2);
        complete_range(start.idx + rob_idx_t'(2), ROB_SIZE, -1, EXC_NONE);
        wait_drain();
    endtask

    task automatic exception_flush();
        rob_ptr_t start;
        int       c0;
        int       e0;
        start = exp_tail;
        c0    = commit_total;
        e0    = exc_seen;
        alloc_burst(4);
        complete_range(start.idx, 4, 2, 4'h5);
        wait_drain();
        repeat (4) @(posedge clk);
        check_eq(32'(commit_total), 32'(c0 + 2), "commits before the fault");
        check_eq(32'(exc_seen), 32'(e0 + 1), "exc_valid pulses");
        check_eq(32'(exc_ptr_seen), 32'(start + 5'd2), "exc_ptr of third entry");
        check_eq(32'(exc_code_seen), 32'h5, "exc_code of third entry");
        // flushed buffer takes a full lap again
        start = exp_tail;
        alloc_burst(ROB_SIZE);
        complete_range(start.idx, ROB_SIZE, -1, EXC_NONE);
        wait_drain();
    endtask

    task automatic exception_lane0_wrap();
        rob_ptr_t start;
        logic     w0;
        int       fill;
        int       c0;
        int       e0;
        w0    = exp_tail.wrap;
        fill  = ROB_SIZE - int'(exp_tail.idx);
        start = exp_tail;
        alloc_burst(fill);
        complete_range(start.idx, fill, -1, EXC_NONE);
        wait_drain();
        start = exp_tail;
        c0    = commit_total;
        e0    = exc_seen;
        alloc_burst(2);
        complete_range(start.idx, 2, 0, 4'h9);
        wait_drain();
        repeat (4) @(posedge clk);
        check_eq(32'(exc_seen), 32'(e0 + 1), "exc_valid pulses in lane 0");
        check_eq(32'(exc_ptr_seen), 32'({~w0, 4'h0}), "exc_ptr past the wrap");
        check_eq(32'(exc_lanes_seen), 0, "commit_en beside a lane 0 fault");
        check_eq(32'(commit_total), 32'(c0), "commits after a lane 0 fault");
    endtask

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST FAILED");
        $fatal(1);
    end

    initial begin : main
        void'($urandom(32'h9094_ec5b));
        rst          = 1'b0;
        alloc_num    = '0;
        alloc_entry  = '0;
        wb_en        = '0;
        wb_idx       = '0;
        wb_exc       = '0;
        exp_tail     = '0;
        commit_total = 0;
        exc_seen     = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b1;
        reset_and_alloc_ptrs();
        inorder_commit();
        full_backpressure();
        exception_flush();
        exception_lane0_wrap();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: rob.f
hw/rob_pkg.sv
hw/rob_head_if.sv
hw/rob_ptrs.sv
hw/rob_status.sv
hw/rob_entry_ram.sv
hw/rob_commit.sv
hw/rob.sv
tests/rob_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= rob_tb
LINT_TOP  ?= rob
FILELIST  ?= rob.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
